// ==== Bender.yml ====
package:
  name: uart_apb

sources:
  - rtl/uart_pkg.sv
  - rtl/uart_rx_fifo.sv
  - rtl/uart_rx.sv
  - rtl/uart_tx.sv
  - rtl/uart_apb_regs.sv
  - rtl/uart_apb_top.sv
  - target: simulation
    files:
      - sim/tb_uart_apb_top.sv

// ==== rtl/uart_apb_regs.sv ====
// UART APB register block
`timescale 1ns/1ps

module uart_apb_regs (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  uart_pkg::apb_req_t   apb_req_i,
    output uart_pkg::apb_rsp_t   apb_rsp_o,
    output uart_pkg::uart_cfg_t  cfg_o,
    output logic                 tx_start_o,
    output logic [7:0]           tx_data_o,
    input  logic                 tx_busy_i,
    input  uart_pkg::rx_result_t rx_result_i,
    output logic                 fifo_pop_o,
    input  logic [7:0]           fifo_data_i,
    input  logic                 fifo_empty_i,
    input  logic                 fifo_full_i,
    input  logic                 fifo_push_drop_i
);
    import uart_pkg::*;

    uart_cfg_t   cfg_q;
    logic        overrun_q;
    logic        frame_err_q;
    reg_addr_e   addr;
    logic        access;
    logic        addr_hit;
    logic        wr_en;
    logic        rd_en;
    logic        status_wr;
    logic [31:0] status;
    logic [31:0] rdata;

    // access cycle of a transfer, never stalled
    assign access = apb_req_i.psel & apb_req_i.penable;
    assign addr   = reg_addr_e'(apb_req_i.paddr[3:0]);

    always_comb begin
        addr_hit = 1'b0;
        if (apb_req_i.paddr[7:4] == 4'h0) begin
            case (addr)
                ADDR_DATA, ADDR_STATUS, ADDR_CTRL, ADDR_BAUD: addr_hit = 1'b1;
                default: addr_hit = 1'b0;
            endcase
        end
    end

    assign wr_en     = access & apb_req_i.pwrite & addr_hit;
    assign rd_en     = access & ~apb_req_i.pwrite & addr_hit;
    assign status_wr = wr_en & (addr == ADDR_STATUS);

    always_comb begin
        status                 = '0;
        status[STAT_TX_BUSY]   = tx_busy_i;
        status[STAT_RX_EMPTY]  = fifo_empty_i;
        status[STAT_RX_FULL]   = fifo_full_i;
        status[STAT_OVERRUN]   = overrun_q;
        status[STAT_FRAME_ERR] = frame_err_q;
    end

    always_comb begin
        rdata = '0;
        if (rd_en) begin
            case (addr)
                ADDR_DATA:   rdata[7:0]  = fifo_empty_i ? 8'h00 : fifo_data_i;
                ADDR_STATUS: rdata       = status;
                ADDR_CTRL:   rdata[1:0]  = {cfg_q.tx_en, cfg_q.rx_en};
                ADDR_BAUD:   rdata[15:0] = cfg_q.baud_div;
                default:     rdata       = '0;
            endcase
        end
    end

    assign apb_rsp_o.prdata  = rdata;
    assign apb_rsp_o.pready  = 1'b1;
    assign apb_rsp_o.pslverr = access & ~addr_hit;

    // a DATA write while the transmitter is busy is silently dropped
    assign tx_start_o = wr_en & (addr == ADDR_DATA) & cfg_q.tx_en & ~tx_busy_i;
    assign tx_data_o  = apb_req_i.pwdata[7:0];
    assign fifo_pop_o = rd_en & (addr == ADDR_DATA) & ~fifo_empty_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cfg_q.baud_div <= BAUD_RESET;
            cfg_q.rx_en    <= 1'b0;
            cfg_q.tx_en    <= 1'b0;
        end else if (wr_en) begin
            if (addr == ADDR_CTRL) begin
                cfg_q.rx_en <= apb_req_i.pwdata[0];
                cfg_q.tx_en <= apb_req_i.pwdata[1];
            end
            if (addr == ADDR_BAUD) begin
                cfg_q.baud_div <= apb_req_i.pwdata[15:0];
            end
        end
    end

    // sticky flags, a new event wins over a clear in the same cycle
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            overrun_q   <= 1'b0;
            frame_err_q <= 1'b0;
        end else begin
            overrun_q   <= fifo_push_drop_i
                         | (overrun_q & ~(status_wr & apb_req_i.pwdata[STAT_OVERRUN]));
            frame_err_q <= (rx_result_i.valid & rx_result_i.frame_err)
                         | (frame_err_q & ~(status_wr & apb_req_i.pwdata[STAT_FRAME_ERR]));
        end
    end

    assign cfg_o = cfg_q;

endmodule

// ==== rtl/uart_apb_top.sv ====
// APB UART top level
`timescale 1ns/1ps

module uart_apb_top (
    input  logic               clk_i,
    input  logic               rst_i,
    input  uart_pkg::apb_req_t apb_req_i,
    output uart_pkg::apb_rsp_t apb_rsp_o,
    input  logic               rx_i,
    output logic               tx_o
);
    import uart_pkg::*;

    uart_cfg_t  cfg;
    rx_result_t rx_result;
    logic       tx_start;
    logic [7:0] tx_data;
    logic       tx_busy;
    logic       fifo_push;
    logic       fifo_pop;
    logic [7:0] fifo_head;
    logic       fifo_empty;
    logic       fifo_full;
    logic       fifo_push_drop;

    // frames with a bad stop bit never reach the FIFO
    assign fifo_push = rx_result.valid & ~rx_result.frame_err;

    uart_apb_regs i_regs (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .apb_req_i        (apb_req_i),
        .apb_rsp_o        (apb_rsp_o),
        .cfg_o            (cfg),
        .tx_start_o       (tx_start),
        .tx_data_o        (tx_data),
        .tx_busy_i        (tx_busy),
        .rx_result_i      (rx_result),
        .fifo_pop_o       (fifo_pop),
        .fifo_data_i      (fifo_head),
        .fifo_empty_i     (fifo_empty),
        .fifo_full_i      (fifo_full),
        .fifo_push_drop_i (fifo_push_drop)
    );

    uart_rx i_rx (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .rx_i     (rx_i),
        .cfg_i    (cfg),
        .result_o (rx_result)
    );

    uart_tx i_tx (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .start_i    (tx_start),
        .data_i     (tx_data),
        .baud_div_i (cfg.baud_div),
        .busy_o     (tx_busy),
        .tx_o       (tx_o)
    );

    uart_rx_fifo i_fifo (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .push_i      (fifo_push),
        .push_data_i (rx_result.data),
        .pop_i       (fifo_pop),
        .head_o      (fifo_head),
        .empty_o     (fifo_empty),
        .full_o      (fifo_full),
        .push_drop_o (fifo_push_drop)
    );

endmodule

// ==== rtl/uart_pkg.sv ====
// UART peripheral shared definitions
package uart_pkg;

    // ########################################################################
    // sizes and reset values
    // ########################################################################

    localparam int unsigned FIFO_DEPTH = 4;
    localparam int unsigned FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int unsigned FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

    // one bit lasts baud_div + 1 cycles, smallest usable divisor is 3
    localparam logic [15:0] BAUD_RESET = 16'd433;

    // STATUS register bit positions, overrun and frame_err are sticky
    localparam int unsigned STAT_TX_BUSY   = 0;
    localparam int unsigned STAT_RX_EMPTY  = 1;
    localparam int unsigned STAT_RX_FULL   = 2;
    localparam int unsigned STAT_OVERRUN   = 3;
    localparam int unsigned STAT_FRAME_ERR = 4;

    // ########################################################################
    // encodings
    // ########################################################################

    // decoded from paddr[3:0]
    typedef enum logic [3:0] {
        ADDR_DATA   = 4'h0,
        ADDR_STATUS = 4'h4,
        ADDR_CTRL   = 4'h8,
        ADDR_BAUD   = 4'hC
    } reg_addr_e;

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;
    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;

    // ########################################################################
    // bundles
    // ########################################################################

    typedef struct packed {
        logic [7:0]  paddr;
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic [15:0] baud_div;
        logic        rx_en;
        logic        tx_en;
    } uart_cfg_t;

    // one finished frame, valid for a single cycle
    typedef struct packed {
        logic [7:0] data;
        logic       valid;
        logic       frame_err;
    } rx_result_t;

endpackage

// ==== rtl/uart_rx.sv ====
// UART serial receiver
`timescale 1ns/1ps

module uart_rx (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 rx_i,
    input  uart_pkg::uart_cfg_t  cfg_i,
    output uart_pkg::rx_result_t result_o
);
    import uart_pkg::*;

    rx_state_e   state_q;
    logic        rx_meta_q;
    logic        rx_sync_q;
    logic [15:0] cnt_q;
    logic [15:0] half_bit;
    logic [2:0]  bit_idx_q;
    logic [7:0]  data_q;
    logic        stop_seen_q;
    logic        bit_end;
    logic        stop_sample;

    // two-flop synchronizer, line idles high
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rx_meta_q <= 1'b1;
            rx_sync_q <= 1'b1;
        end else begin
            rx_meta_q <= rx_i;
            rx_sync_q <= rx_meta_q;
        end
    end

    assign half_bit    = {1'b0, cfg_i.baud_div[15:1]};
    assign bit_end     = (cnt_q == cfg_i.baud_div);
    assign stop_sample = (state_q == RX_STOP) & ~stop_seen_q & bit_end;

    // ########################################################################
    // frame FSM
    // ########################################################################

    always_ff @(posedge clk_i) begin
        if (rst_i || !cfg_i.rx_en) begin
            state_q     <= RX_IDLE;
            cnt_q       <= '0;
            bit_idx_q   <= '0;
            stop_seen_q <= 1'b0;
        end else begin
            case (state_q)
                RX_IDLE: begin
                    cnt_q <= '0;
                    if (!rx_sync_q) begin
                        state_q <= RX_START;
                    end
                end
                RX_START: begin
                    // line back high at mid start bit means a glitch
                    if (cnt_q == half_bit) begin
                        cnt_q   <= '0;
                        state_q <= rx_sync_q ? RX_IDLE : RX_DATA;
                    end else begin
                        cnt_q <= cnt_q + 16'd1;
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        cnt_q     <= '0;
                        bit_idx_q <= bit_idx_q + 3'd1;
                        if (bit_idx_q == 3'd7) begin
                            state_q <= RX_STOP;
                        end
                    end else begin
                        cnt_q <= cnt_q + 16'd1;
                    end
                end
                RX_STOP: begin
                    // sample mid stop bit, then wait out its second half
                    if (stop_sample) begin
                        cnt_q       <= '0;
                        stop_seen_q <= 1'b1;
                    end else if (stop_seen_q && cnt_q == half_bit) begin
                        cnt_q       <= '0;
                        stop_seen_q <= 1'b0;
                        state_q     <= RX_IDLE;
                    end else begin
                        cnt_q <= cnt_q + 16'd1;
                    end
                end
                default: state_q <= RX_IDLE;
            endcase
        end
    end

    // lsb arrives first, so shift in from the top
    always_ff @(posedge clk_i) begin
        if (state_q == RX_DATA && bit_end) begin
            data_q <= {rx_sync_q, data_q[7:1]};
        end
    end

    assign result_o.data      = data_q;
    assign result_o.valid     = stop_sample & cfg_i.rx_en;
    assign result_o.frame_err = ~rx_sync_q;

endmodule

// ==== rtl/uart_rx_fifo.sv ====
// UART receive FIFO
`timescale 1ns/1ps

module uart_rx_fifo (
    input  logic       clk_i,
    input  logic       rst_i,
    input  logic       push_i,
    input  logic [7:0] push_data_i,
    input  logic       pop_i,
    output logic [7:0] head_o,
    output logic       empty_o,
    output logic       full_o,
    output logic       push_drop_o
);
    import uart_pkg::*;

    logic [7:0]            mem_q [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr_q;
    logic [FIFO_PTR_W-1:0] rd_ptr_q;
    logic [FIFO_CNT_W-1:0] count_q;
    logic                  do_push;
    logic                  do_pop;

    assign empty_o = (count_q == '0);
    assign full_o  = (count_q == FIFO_CNT_W'(FIFO_DEPTH));

    // a pop frees the slot for a push in the same cycle
    assign do_pop      = pop_i & ~empty_o;
    assign do_push     = push_i & (~full_o | do_pop);
    assign push_drop_o = push_i & full_o & ~do_pop;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (do_pop && !do_push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

    assign head_o = mem_q[rd_ptr_q];

endmodule

// ==== rtl/uart_tx.sv ====
// UART serial transmitter
`timescale 1ns/1ps

module uart_tx (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        start_i,
    input  logic [7:0]  data_i,
    input  logic [15:0] baud_div_i,
    output logic        busy_o,
    output logic        tx_o
);
    import uart_pkg::*;

    tx_state_e   state_q;
    logic [15:0] cnt_q;
    logic [2:0]  bit_idx_q;
    logic [7:0]  shift_q;
    logic        tx_q;
    logic        bit_end;

    assign bit_end = (cnt_q == baud_div_i);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q   <= TX_IDLE;
            cnt_q     <= '0;
            bit_idx_q <= '0;
            tx_q      <= 1'b1;
        end else begin
            case (state_q)
                TX_IDLE: begin
                    tx_q  <= 1'b1;
                    cnt_q <= '0;
                    if (start_i) begin
                        state_q <= TX_START;
                        tx_q    <= 1'b0;
                    end
                end
                TX_START: begin
                    if (bit_end) begin
                        cnt_q     <= '0;
                        bit_idx_q <= '0;
                        tx_q      <= shift_q[0];
                        state_q   <= TX_DATA;
                    end else begin
                        cnt_q <= cnt_q + 16'd1;
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        cnt_q     <= '0;
                        bit_idx_q <= bit_idx_q + 3'd1;
                        if (bit_idx_q == 3'd7) begin
                            tx_q    <= 1'b1;
                            state_q <= TX_STOP;
                        end else begin
                            tx_q <= shift_q[0];
                        end
                    end else begin
                        cnt_q <= cnt_q + 16'd1;
                    end
                end
                TX_STOP: begin
                    if (bit_end) begin
                        cnt_q   <= '0;
                        state_q <= TX_IDLE;
                    end else begin
                        cnt_q <= cnt_q + 16'd1;
                    end
                end
                default: state_q <= TX_IDLE;
            endcase
        end
    end

    // byte latched on start, consumed one bit at each bit boundary
    always_ff @(posedge clk_i) begin
        if (state_q == TX_IDLE && start_i) begin
            shift_q <= data_i;
        end else if ((state_q == TX_START || state_q == TX_DATA) && bit_end) begin
            shift_q <= {1'b0, shift_q[7:1]};
        end
    end

    assign busy_o = (state_q != TX_IDLE);
    assign tx_o   = tx_q;

endmodule

// ==== sim/tb_uart_apb_top.sv ====
// APB UART testbench
`timescale 1ns/1ps

module tb_uart_apb_top;
    import uart_pkg::*;

    localparam int BAUD_DIV     = 7;
    localparam int BIT_CYCLES   = BAUD_DIV + 1;
    localparam int FRAME_CYCLES = 10 * BIT_CYCLES;
    localparam int APB_WAIT     = 16;
    localparam int TX_WAIT      = 4 * FRAME_CYCLES;

    localparam logic [7:0] REG_DATA   = {4'h0, ADDR_DATA};
    localparam logic [7:0] REG_STATUS = {4'h0, ADDR_STATUS};
    localparam logic [7:0] REG_CTRL   = {4'h0, ADDR_CTRL};
    localparam logic [7:0] REG_BAUD   = {4'h0, ADDR_BAUD};

    logic     clk_i;
    logic     rst_i;
    logic     rx_i;
    logic     tx_o;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;

    uart_apb_top i_dut (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .apb_req_i (apb_req),
        .apb_rsp_o (apb_rsp),
        .rx_i      (rx_i),
        .tx_o      (tx_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // ########################################################################
    // reference model and random bytes
    // ########################################################################

    logic [7:0]  model_q[$];
    logic        model_overrun   = 1'b0;
    logic        model_frame_err = 1'b0;
    logic [31:0] lfsr_q          = 32'hb048_5ea5;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    function automatic logic [7:0] rand_byte();
        logic [7:0] b;
        int         k;
        b = '0;
        for (k = 0; k < 8; k++) begin
            lfsr_q = lfsr_step(lfsr_q);
            b      = {b[6:0], lfsr_q[0]};
        end
        return b;
    endfunction

    // a full FIFO drops the new byte and raises overrun
    function automatic void model_push(input logic [7:0] b);
        if (model_q.size() < FIFO_DEPTH) begin
            model_q.push_back(b);
        end else begin
            model_overrun = 1'b1;
        end
    endfunction

    function automatic logic [7:0] model_pop();
        if (model_q.size() == 0) begin
            return 8'h00;
        end
        return model_q.pop_front();
    endfunction

    function automatic logic [31:0] expected_status(input logic tx_busy);
        logic [31:0] s;
        s    = '0;
        s[0] = tx_busy;
        s[1] = (model_q.size() == 0);
        s[2] = (model_q.size() == FIFO_DEPTH);
        s[3] = model_overrun;
        s[4] = model_frame_err;
        return s;
    endfunction

    // ########################################################################
    // compare process
    // ########################################################################

    string       name_q[$];
    logic [31:0] got_q[$];
    logic [31:0] exp_q[$];
    time         time_q[$];
    string       cmp_name;
    logic [31:0] cmp_got;
    logic [31:0] cmp_exp;
    time         cmp_time;
    int          checks     = 0;
    int          mismatches = 0;
    int          timeouts   = 0;

    task automatic expect_eq(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        name_q.push_back(name);
        got_q.push_back(got);
        exp_q.push_back(exp);
        time_q.push_back($time);
    endtask

    always @(negedge clk_i) begin
        while (got_q.size() > 0) begin
            cmp_name = name_q.pop_front();
            cmp_got  = got_q.pop_front();
            cmp_exp  = exp_q.pop_front();
            cmp_time = time_q.pop_front();
            checks++;
            if (cmp_got !== cmp_exp) begin
                $display("[FAIL] t=%0t %s: got 0x%0h, expected 0x%0h",
                         cmp_time, cmp_name, cmp_got, cmp_exp);
                mismatches++;
            end
        end
    end

    // ########################################################################
    // bus and line tasks
    // ########################################################################

    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        int n;
        @(posedge clk_i);
        #2;
        apb_req.paddr   = addr;
        apb_req.pwrite  = wr;
        apb_req.pwdata  = wdata;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        @(posedge clk_i);
        #2;
        apb_req.penable = 1'b1;
        n = 0;
        @(negedge clk_i);
        while (apb_rsp.pready !== 1'b1 && n < APB_WAIT) begin
            @(negedge clk_i);
            n++;
        end
        if (apb_rsp.pready !== 1'b1) begin
            $display("timeout: no pready for access to 0x%02h", addr);
            timeouts++;
        end
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(posedge clk_i);
        #2;
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                             output logic err);
        logic [31:0] unused;
        apb_xfer(1'b1, addr, data, unused, err);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic err);
        apb_xfer(1'b0, addr, 32'h0, data, err);
    endtask

    // start, eight data bits lsb first, stop, then one idle bit
    task automatic drive_frame(input logic [7:0] data, input logic stop_bit);
        logic [9:0] bits;
        int         k;
        bits = {stop_bit, data, 1'b0};
        for (k = 0; k < 10; k++) begin
            @(posedge clk_i);
            #2;
            rx_i = bits[k];
            repeat (BIT_CYCLES - 1) @(posedge clk_i);
        end
        @(posedge clk_i);
        #2;
        rx_i = 1'b1;
        repeat (BIT_CYCLES) @(posedge clk_i);
    endtask

    // samples mid bit and counts the cycles tx_busy stays high
    task automatic watch_tx_frame(output logic [7:0] data, output logic start_lvl,
                                  output logic stop_lvl, output int cycles);
        logic [9:0] bits;
        int         n;
        bits = '1;
        n    = 0;
        @(negedge clk_i);
        while (tx_o !== 1'b0 && n < TX_WAIT) begin
            @(negedge clk_i);
            n++;
        end
        if (tx_o !== 1'b0) begin
            $display("timeout: no start bit on tx_o within %0d cycles", TX_WAIT);
            timeouts++;
        end
        cycles = 0;
        while (i_dut.tx_busy === 1'b1 && cycles < FRAME_CYCLES + 2 * BIT_CYCLES) begin
            if (cycles % BIT_CYCLES == BIT_CYCLES / 2 && cycles / BIT_CYCLES < 10) begin
                bits[cycles / BIT_CYCLES] = tx_o;
            end
            cycles++;
            @(negedge clk_i);
        end
        if (i_dut.tx_busy === 1'b1) begin
            $display("timeout: tx_busy still high after a full frame");
            timeouts++;
        end
        data      = bits[8:1];
        start_lvl = bits[0];
        stop_lvl  = bits[9];
    endtask

    task automatic count_tx_low(input int window, output int lows);
        int n;
        lows = 0;
        for (n = 0; n < window; n++) begin
            @(negedge clk_i);
            if (tx_o !== 1'b1) begin
                lows++;
            end
        end
    endtask

    // ########################################################################
    // test sequence
    // ########################################################################

    logic        err;
    logic [31:0] rdata;
    logic [7:0]  tx_byte;
    logic [7:0]  mon_byte;
    logic        mon_start;
    logic        mon_stop;
    int          mon_cycles;
    int          lows;
    int          i;
    int          n;

    initial begin
        rst_i   = 1'b1;
        rx_i    = 1'b1;
        apb_req = '0;
        repeat (5) @(posedge clk_i);
        #2;
        rst_i = 1'b0;

        // reset values and configuration
        apb_read(REG_STATUS, rdata, err);
        expect_eq("STATUS after reset", rdata, expected_status(1'b0));
        apb_read(REG_CTRL, rdata, err);
        expect_eq("CTRL after reset", rdata, 32'h0);
        apb_read(REG_BAUD, rdata, err);
        expect_eq("BAUD after reset", rdata, 32'd433);
        apb_write(REG_BAUD, BAUD_DIV, err);
        expect_eq("pslverr on BAUD write", err, 1'b0);
        apb_read(REG_BAUD, rdata, err);
        expect_eq("BAUD readback", rdata, BAUD_DIV);
        apb_write(8'h10, 32'hffff_ffff, err);
        expect_eq("pslverr on unmapped write", err, 1'b1);
        apb_read(8'h06, rdata, err);
        expect_eq("pslverr on unmapped read", err, 1'b1);
        expect_eq("prdata on unmapped read", rdata, 32'h0);

        // transmit with a second write while busy
        apb_write(REG_CTRL, 32'h2, err);
        for (i = 0; i < 3; i++) begin
            tx_byte = rand_byte();
            fork
                watch_tx_frame(mon_byte, mon_start, mon_stop, mon_cycles);
                begin
                    apb_write(REG_DATA, {24'h0, tx_byte}, err);
                    apb_read(REG_STATUS, rdata, err);
                    expect_eq("STATUS during frame", rdata, expected_status(1'b1));
                    apb_write(REG_DATA, {24'h0, ~tx_byte}, err);
                end
            join
            expect_eq("tx_o start bit", mon_start, 1'b0);
            expect_eq("tx_o stop bit", mon_stop, 1'b1);
            expect_eq("tx_o data", mon_byte, tx_byte);
            expect_eq("tx_busy frame cycles", mon_cycles, FRAME_CYCLES);
            count_tx_low(2 * FRAME_CYCLES, lows);
            expect_eq("tx_o low samples after frame", lows, 0);
            apb_read(REG_STATUS, rdata, err);
            expect_eq("STATUS after frame", rdata, expected_status(1'b0));
        end

        // receive three bytes
        apb_write(REG_CTRL, 32'h3, err);
        for (i = 0; i < 3; i++) begin
            tx_byte = rand_byte();
            drive_frame(tx_byte, 1'b1);
            model_push(tx_byte);
        end
        for (i = 0; i < 3; i++) begin
            apb_read(REG_DATA, rdata, err);
            expect_eq("DATA read", rdata, {24'h0, model_pop()});
        end
        apb_read(REG_STATUS, rdata, err);
        expect_eq("STATUS after receive", rdata, expected_status(1'b0));

        // overrun on the fifth frame
        for (i = 0; i < 5; i++) begin
            tx_byte = rand_byte();
            drive_frame(tx_byte, 1'b1);
            model_push(tx_byte);
        end
        apb_read(REG_STATUS, rdata, err);
        expect_eq("STATUS after overrun", rdata, expected_status(1'b0));
        for (i = 0; i < 5; i++) begin
            apb_read(REG_DATA, rdata, err);
            expect_eq("DATA read after overrun", rdata, {24'h0, model_pop()});
        end
        apb_write(REG_STATUS, 32'h8, err);
        model_overrun = 1'b0;
        apb_read(REG_STATUS, rdata, err);
        expect_eq("STATUS after overrun clear", rdata, expected_status(1'b0));

        // bad stop bit, then a frame with the receiver off
        drive_frame(rand_byte(), 1'b0);
        model_frame_err = 1'b1;
        apb_read(REG_STATUS, rdata, err);
        expect_eq("STATUS after framing error", rdata, expected_status(1'b0));
        apb_read(REG_DATA, rdata, err);
        expect_eq("DATA after framing error", rdata, {24'h0, model_pop()});
        apb_write(REG_STATUS, 32'h10, err);
        model_frame_err = 1'b0;
        apb_write(REG_CTRL, 32'h2, err);
        drive_frame(rand_byte(), 1'b1);
        apb_read(REG_STATUS, rdata, err);
        expect_eq("STATUS with rx disabled", rdata, expected_status(1'b0));
        apb_read(REG_DATA, rdata, err);
        expect_eq("DATA with rx disabled", rdata, {24'h0, model_pop()});

        n = 0;
        while (got_q.size() > 0 && n < 8) begin
            @(negedge clk_i);
            n++;
        end
        if (got_q.size() > 0) begin
            $display("compare queue still holds %0d entries at the end", got_q.size());
            timeouts++;
        end
        $display("checks %0d, mismatches %0d, timeouts %0d", checks, mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== uart_apb_top.f ====
rtl/uart_pkg.sv
rtl/uart_rx_fifo.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/uart_apb_regs.sv
rtl/uart_apb_top.sv
sim/tb_uart_apb_top.sv
